//--- uart_dbg_soc.f
+incdir+.
wb_pkg.sv
uart_dbg_pkg.sv
uart_phy.sv
uart_dbg_engine.sv
wb_arbiter.sv
wb_sram.sv
uart_dbg_soc_top.sv
tb_uart_dbg_soc.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the UART debug SoC testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_uart_dbg_soc -f uart_dbg_soc.f -o tb_uart_dbg_soc
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_uart_dbg_soc > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "=== FAIL ===" "$log"; then
  echo "Simulation failed, see $log"
  exit 1
fi

echo "Simulation passed"
exit 0

//--- tb_uart_dbg_soc.sv
`timescale 1ns/1ps
`include "uart_dbg_soc_macros.svh"

module tb_uart_dbg_soc
  import wb_pkg::*;
  import uart_dbg_pkg::*;
();

  localparam int BIT_CLKS   = `UDS_CLKS_PER_BIT;
  localparam int BYTE_WAIT  = 40 * BIT_CLKS;
  localparam int QUIET_CLKS = 30 * BIT_CLKS;

  logic    clk = 1'b0;
  logic    rst_n_i;
  logic    uart_rx;
  logic    uart_tx;
  wb_req_t ext_req;
  wb_rsp_t ext_rsp;

  int   errors;
  int   checks;
  int   timeouts;
  int   frame_errors;
  int   idle_errors;
  int   ack_errors;
  logic stim_started;
  int   max_lat;
  int   last_lat;

  // Bytes seen on the UART transmit line in order
  byte_t tx_seen [$];
  int    rd_ptr;
  logic  mon_busy;
  int    mon_cnt;
  int    mon_idx;
  byte_t mon_shift;

  // Expected memory contents per byte address
  byte_t model_mem [1024];
  bit    model_ok  [1024];

  uart_dbg_soc_top uut (
    .clk          ( clk     ),
    .rst_n_i      ( rst_n_i ),
    .uart_rx_i    ( uart_rx ),
    .uart_tx_o    ( uart_tx ),
    .ext_wb_req_i ( ext_req ),
    .ext_wb_rsp_o ( ext_rsp )
  );

  always #50 clk = ~clk;

  //////////////////////////////////////////////////
  // Bus and line properties
  //////////////////////////////////////////////////

  // Line idle and no ack before the first stimulus
  idle_quiet: assert property (@(posedge clk) disable iff (!rst_n_i)
      !stim_started |-> (uart_tx && !ext_rsp.ack))
    else begin
      idle_errors++;
      $display("FAILED at %0t: UART line or external ack active before any stimulus", $time);
    end

  ack_single: assert property (@(posedge clk) disable iff (!rst_n_i)
      ext_rsp.ack |=> !ext_rsp.ack)
    else begin
      ack_errors++;
      $display("FAILED at %0t: external ack high in two cycles in a row", $time);
    end

  //////////////////////////////////////////////////
  // UART transmit monitor
  //////////////////////////////////////////////////

  // Samples at mid-bit on the falling clock edge
  always @(negedge clk) begin
    if (!rst_n_i) begin
      mon_busy = 1'b0;
    end else if (!mon_busy) begin
      if (uart_tx == 1'b0) begin
        mon_busy = 1'b1;
        mon_cnt  = BIT_CLKS / 2 - 1;
        mon_idx  = 0;
      end
    end else if (mon_cnt != 0) begin
      mon_cnt--;
    end else begin
      mon_cnt = BIT_CLKS - 1;
      if (mon_idx == 0) begin
        assert (!uart_tx) else begin
          frame_errors++;
          $display("FAILED at %0t: UART start bit not low at mid-bit", $time);
        end
      end else if (mon_idx <= 8) begin
        mon_shift = {uart_tx, mon_shift[7:1]};
      end else begin
        assert (uart_tx) else begin
          frame_errors++;
          $display("FAILED at %0t: UART stop bit low", $time);
        end
        tx_seen.push_back(mon_shift);
        mon_busy = 1'b0;
      end
      mon_idx++;
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic check_word(input wb_dat_t got, input wb_dat_t exp, input string what);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_byte(input byte_t got, input byte_t exp, input string what);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  // 8N1 frame sent LSB first
  task automatic send_byte(input byte_t b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      uart_rx = frame[i];
      repeat (BIT_CLKS) tick();
    end
  endtask

  task automatic send_field(input logic [63:0] v);
    for (int i = 0; i < `UDS_FIELD_BYTES; i++) begin
      send_byte(v[8*i +: 8]);
    end
  endtask

  // Upper bytes carry noise that the engine drops
  task automatic send_cmd(input byte_t cmd, input int base, input int len);
    send_byte(cmd);
    send_field({$urandom(), 22'($urandom()), 10'(base)});
    send_field({$urandom(), 16'($urandom()), 16'(len)});
  endtask

  task automatic wait_tx(input int n, input int max_clks);
    int waited;
    waited = 0;
    while (tx_seen.size() - rd_ptr < n && waited < max_clks) begin
      tick();
      waited++;
    end
    if (tx_seen.size() - rd_ptr < n) begin
      timeouts++;
      $display("Timeout at %0t: waited %0d clocks for a UART byte, none arrived",
               $time, waited);
    end
  endtask

  task automatic expect_tx(input byte_t exp, input string what);
    wait_tx(1, BYTE_WAIT);
    if (tx_seen.size() > rd_ptr) begin
      check_byte(tx_seen[rd_ptr], exp, what);
      rd_ptr++;
    end
  endtask

  task automatic expect_quiet(input string what);
    repeat (QUIET_CLKS) tick();
    check_word(tx_seen.size() - rd_ptr, 0, what);
  endtask

  task automatic uart_write(input int base, input int len);
    byte_t d;
    send_cmd(`UDS_CMD_WRITE, base, len);
    for (int i = 0; i < len; i++) begin
      d = 8'($urandom());
      send_byte(d);
      model_mem[base + i] = d;
      model_ok[base + i]  = 1'b1;
    end
  endtask

  task automatic uart_read_check(input int base, input int len);
    send_cmd(`UDS_CMD_READ, base, len);
    expect_tx(`UDS_ACK, "ACK for read");
    for (int i = 0; i < len; i++) begin
      expect_tx(model_mem[base + i], $sformatf("UART read of byte %0d", base + i));
    end
    expect_tx(`UDS_EOT, "EOT for read");
  endtask

  // Request held until ack, then through the ack cycle
  task automatic ext_access(input logic we, input int w, input wb_dat_t wdat,
                            output wb_dat_t rdat);
    int   waited;
    logic seen;
    ext_req.cyc = 1'b1;
    ext_req.stb = 1'b1;
    ext_req.we  = we;
    ext_req.adr = wb_adr_t'(w);
    ext_req.sel = '1;
    ext_req.dat = wdat;
    waited = 0;
    seen   = 1'b0;
    rdat   = '0;
    while (!seen && waited < 200) begin
      tick();
      waited++;
      if (ext_rsp.ack) begin
        seen = 1'b1;
        rdat = ext_rsp.dat;
      end
    end
    if (!seen) begin
      timeouts++;
      $display("Timeout at %0t: external access to word %0d got no ack in %0d clocks",
               $time, w, waited);
    end else begin
      last_lat = waited;
      if (waited > max_lat) max_lat = waited;
      tick();
      checks++;
      assert (!ext_rsp.ack) else begin
        errors++;
        $display("FAILED at %0t: second ack for one access to word %0d", $time, w);
      end
    end
    ext_req = '0;
  endtask

  task automatic ext_write_word(input int w, input wb_dat_t d);
    wb_dat_t ignored;
    ext_access(1'b1, w, d, ignored);
    for (int l = 0; l < 4; l++) begin
      model_mem[4*w + l] = d[8*l +: 8];
      model_ok[4*w + l]  = 1'b1;
    end
  endtask

  // Lanes in little-endian order with unknown bytes masked off
  task automatic ext_check_word(input int w);
    wb_dat_t got;
    wb_dat_t exp;
    wb_dat_t mask;
    exp  = '0;
    mask = '0;
    for (int l = 0; l < 4; l++) begin
      exp[8*l +: 8] = model_mem[4*w + l];
      if (model_ok[4*w + l]) mask[8*l +: 8] = 8'hff;
    end
    ext_access(1'b0, w, '0, got);
    check_word(got & mask, exp & mask, $sformatf("external read of word %0d", w));
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    int base;
    int first_base;
    int len;
    int w;
    void'($urandom(32'h1e91_05b1));
    rst_n_i      = 1'b0;
    uart_rx      = 1'b1;
    ext_req      = '0;
    stim_started = 1'b0;
    errors       = 0;
    checks       = 0;
    timeouts     = 0;
    frame_errors = 0;
    idle_errors  = 0;
    ack_errors   = 0;
    max_lat      = 0;
    last_lat     = 0;
    rd_ptr       = 0;
    repeat (5) tick();
    rst_n_i = 1'b1;
    repeat (4 * BIT_CLKS) tick();
    stim_started = 1'b1;

    // ACK challenge
    send_byte(`UDS_ACK);
    expect_tx(`UDS_ACK, "reply to ACK challenge");
    expect_quiet("extra UART bytes after ACK reply");

    // UART write followed by UART and external read back
    first_base = 0;
    for (int n = 0; n < 3; n++) begin
      base = $urandom_range(499, 0);
      len  = $urandom_range(12, 1);
      if (n == 0) first_base = base;
      uart_write(base, len);
      expect_tx(`UDS_ACK, "ACK for write");
      expect_tx(`UDS_EOT, "EOT for write");
      uart_read_check(base, len);
      for (w = base / 4; w <= (base + len - 1) / 4; w++) begin
        ext_check_word(w);
        check_word(last_lat, 1, "external latency with idle engine");
      end
    end

    // External words read back over UART
    w = $urandom_range(254, 128);
    for (int k = 0; k < 2; k++) ext_write_word(w + k, $urandom());
    uart_read_check(4 * w, 8);

    // Contention with UART bytes below word 128 and external words above
    base = $urandom_range(499, 0);
    fork
      uart_write(base, 12);
      begin
        repeat (16 * 10 * BIT_CLKS) tick();
        for (int k = 0; k < 400; k++) begin
          w = $urandom_range(255, 128);
          if ($urandom_range(1, 0) == 1) begin
            ext_write_word(w, $urandom());
          end else begin
            ext_check_word(w);
          end
          repeat ($urandom_range(4, 1)) tick();
        end
      end
    join
    expect_tx(`UDS_ACK, "ACK for write under contention");
    expect_tx(`UDS_EOT, "EOT for write under contention");
    checks++;
    assert (max_lat > 1) else begin
      errors++;
      $display("FAILED at %0t: no external access waited for the engine, longest %0d clocks",
               $time, max_lat);
    end
    uart_read_check(base, 12);
    for (w = 128; w < 256; w++) ext_check_word(w);

    // Zero length commands leave memory alone
    send_cmd(`UDS_CMD_WRITE, first_base, 0);
    expect_tx(`UDS_ACK, "ACK for empty write");
    expect_tx(`UDS_EOT, "EOT right after ACK for empty write");
    for (w = first_base / 4; w < first_base / 4 + 4; w++) ext_check_word(w);
    send_cmd(`UDS_CMD_READ, first_base, 0);
    expect_tx(`UDS_ACK, "ACK for empty read");
    expect_tx(`UDS_EOT, "EOT right after ACK for empty read");

    // Stray byte outside a command
    send_byte(8'h55);
    expect_quiet("UART bytes after a stray 55h");

    $display("Checks %0d, errors %0d, frame %0d, idle %0d, ack %0d, timeouts %0d",
             checks, errors, frame_errors, idle_errors, ack_errors, timeouts);
    if (errors + frame_errors + idle_errors + ack_errors + timeouts == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- uart_dbg_soc_top.sv
`timescale 1ns/1ps

module uart_dbg_soc_top import wb_pkg::*; import uart_dbg_pkg::*; (
  input  logic    clk,
  input  logic    rst_n_i,
  input  logic    uart_rx_i,
  output logic    uart_tx_o,
  input  wb_req_t ext_wb_req_i,
  output wb_rsp_t ext_wb_rsp_o
);

  // Byte streams between phy and engine
  logic    rx_valid;
  byte_t   rx_byte;
  logic    tx_valid;
  byte_t   tx_byte;
  logic    tx_ready;

  // Bus segments
  wb_req_t eng_req;
  wb_rsp_t eng_rsp;
  wb_req_t sram_req;
  wb_rsp_t sram_rsp;

  uart_phy u_phy (
    .clk        ( clk       ),
    .rst_n_i    ( rst_n_i   ),
    .uart_rx_i  ( uart_rx_i ),
    .uart_tx_o  ( uart_tx_o ),
    .rx_valid_o ( rx_valid  ),
    .rx_byte_o  ( rx_byte   ),
    .tx_valid_i ( tx_valid  ),
    .tx_byte_i  ( tx_byte   ),
    .tx_ready_o ( tx_ready  )
  );

  uart_dbg_engine u_engine (
    .clk        ( clk      ),
    .rst_n_i    ( rst_n_i  ),
    .rx_valid_i ( rx_valid ),
    .rx_byte_i  ( rx_byte  ),
    .tx_valid_o ( tx_valid ),
    .tx_byte_o  ( tx_byte  ),
    .tx_ready_i ( tx_ready ),
    .wb_req_o   ( eng_req  ),
    .wb_rsp_i   ( eng_rsp  )
  );

  // Engine on m0, external port on m1
  wb_arbiter u_arb (
    .clk      ( clk          ),
    .rst_n_i  ( rst_n_i      ),
    .m0_req_i ( eng_req      ),
    .m0_rsp_o ( eng_rsp      ),
    .m1_req_i ( ext_wb_req_i ),
    .m1_rsp_o ( ext_wb_rsp_o ),
    .s_req_o  ( sram_req     ),
    .s_rsp_i  ( sram_rsp     )
  );

  wb_sram u_sram (
    .clk      ( clk      ),
    .rst_n_i  ( rst_n_i  ),
    .wb_req_i ( sram_req ),
    .wb_rsp_o ( sram_rsp )
  );

endmodule

//--- wb_sram.sv
`timescale 1ns/1ps
`include "uart_dbg_soc_macros.svh"

module wb_sram import wb_pkg::*; (
  input  logic    clk,
  input  logic    rst_n_i,
  input  wb_req_t wb_req_i,
  output wb_rsp_t wb_rsp_o
);

  localparam int LANES = `UDS_DW / 8;

  wb_dat_t mem_q [2**`UDS_MEM_AW];
  wb_dat_t rdata_q;
  logic    ack_q;
  logic    access;

  // No new access in the ack cycle, so one ack per access
  assign access = wb_req_i.cyc & wb_req_i.stb & ~ack_q;

  always_ff @(posedge clk) begin
    if (access) begin
      if (wb_req_i.we) begin
        for (int i = 0; i < LANES; i++) begin
          if (wb_req_i.sel[i]) mem_q[wb_req_i.adr][8*i +: 8] <= wb_req_i.dat[8*i +: 8];
        end
      end
      rdata_q <= mem_q[wb_req_i.adr];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = rdata_q;

endmodule

//--- wb_arbiter.sv
`timescale 1ns/1ps

module wb_arbiter import wb_pkg::*; (
  input  logic    clk,
  input  logic    rst_n_i,
  input  wb_req_t m0_req_i,
  output wb_rsp_t m0_rsp_o,
  input  wb_req_t m1_req_i,
  output wb_rsp_t m1_rsp_o,
  output wb_req_t s_req_o,
  input  wb_rsp_t s_rsp_i
);

  // Zero selects m0, one selects m1
  logic grant_q;
  logic grant_d;

  // Hand over only while the owner has no cycle open
  always_comb begin
    grant_d = grant_q;
    if (!grant_q && !m0_req_i.cyc && m1_req_i.cyc) grant_d = 1'b1;
    if (grant_q && !m1_req_i.cyc && m0_req_i.cyc) grant_d = 1'b0;
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      grant_q <= 1'b0;
    end else begin
      grant_q <= grant_d;
    end
  end

  assign s_req_o = grant_d ? m1_req_i : m0_req_i;

  // Losing master sees no ack and waits
  always_comb begin
    m0_rsp_o = '0;
    m1_rsp_o = '0;
    if (grant_d) begin
      m1_rsp_o = s_rsp_i;
    end else begin
      m0_rsp_o = s_rsp_i;
    end
  end

endmodule

//--- uart_dbg_engine.sv
`timescale 1ns/1ps
`include "uart_dbg_soc_macros.svh"

module uart_dbg_engine import wb_pkg::*; import uart_dbg_pkg::*; (
  input  logic    clk,
  input  logic    rst_n_i,
  input  logic    rx_valid_i,
  input  byte_t   rx_byte_i,
  output logic    tx_valid_o,
  output byte_t   tx_byte_o,
  input  logic    tx_ready_i,
  output wb_req_t wb_req_o,
  input  wb_rsp_t wb_rsp_i
);

  localparam int unsigned FCNT_W = $clog2(`UDS_FIELD_BYTES);
  localparam logic [FCNT_W-1:0] FIELD_LAST = FCNT_W'(`UDS_FIELD_BYTES - 1);

  dbg_state_e        state_q;
  byte_t             cmd_q;
  logic [FCNT_W-1:0] field_cnt_q;
  dbg_addr_t         addr_q;
  dbg_len_t          len_q;
  byte_t             data_q;
  logic [1:0]        lane;
  logic              last_byte;

  assign lane      = addr_q[1:0];
  assign last_byte = len_q == dbg_len_t'(1);

  //////////////////////////////////////////////////
  // Command FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q     <= ST_IDLE;
      cmd_q       <= '0;
      field_cnt_q <= '0;
      addr_q      <= '0;
      len_q       <= '0;
    end else begin
      unique case (state_q)
        ST_IDLE: begin
          if (rx_valid_i && rx_byte_i == `UDS_ACK) begin
            cmd_q   <= rx_byte_i;
            state_q <= ST_ACK;
          end else if (rx_valid_i &&
                       (rx_byte_i == `UDS_CMD_READ || rx_byte_i == `UDS_CMD_WRITE)) begin
            cmd_q       <= rx_byte_i;
            addr_q      <= '0;
            len_q       <= '0;
            field_cnt_q <= '0;
            state_q     <= ST_ADDR;
          end
        end
        // Little endian, bytes beyond the decoded width fall off
        ST_ADDR: begin
          if (rx_valid_i) begin
            addr_q      <= addr_q | (dbg_addr_t'(rx_byte_i) << (8 * field_cnt_q));
            field_cnt_q <= field_cnt_q + 1'b1;
            if (field_cnt_q == FIELD_LAST) state_q <= ST_LEN;
          end
        end
        ST_LEN: begin
          if (rx_valid_i) begin
            len_q       <= len_q | (dbg_len_t'(rx_byte_i) << (8 * field_cnt_q));
            field_cnt_q <= field_cnt_q + 1'b1;
            if (field_cnt_q == FIELD_LAST) state_q <= ST_ACK;
          end
        end
        ST_ACK: begin
          if (tx_ready_i) begin
            if (cmd_q == `UDS_ACK) state_q <= ST_IDLE;
            else if (len_q == '0) state_q <= ST_EOT;
            else if (cmd_q == `UDS_CMD_WRITE) state_q <= ST_WR_WAIT;
            else state_q <= ST_RD_BUS;
          end
        end
        ST_WR_WAIT: begin
          if (rx_valid_i) state_q <= ST_WR_BUS;
        end
        ST_WR_BUS: begin
          if (wb_rsp_i.ack) begin
            addr_q  <= addr_q + 1'b1;
            len_q   <= len_q - 1'b1;
            state_q <= last_byte ? ST_EOT : ST_WR_WAIT;
          end
        end
        ST_RD_BUS: begin
          if (wb_rsp_i.ack) state_q <= ST_RD_SEND;
        end
        ST_RD_SEND: begin
          if (tx_ready_i) begin
            addr_q  <= addr_q + 1'b1;
            len_q   <= len_q - 1'b1;
            state_q <= last_byte ? ST_EOT : ST_RD_BUS;
          end
        end
        ST_EOT: begin
          if (tx_ready_i) state_q <= ST_IDLE;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Byte to write, or byte picked from the returned word
  always_ff @(posedge clk) begin
    if (state_q == ST_WR_WAIT && rx_valid_i) begin
      data_q <= rx_byte_i;
    end else if (state_q == ST_RD_BUS && wb_rsp_i.ack) begin
      data_q <= wb_rsp_i.dat[8*lane +: 8];
    end
  end

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////

  always_comb begin
    tx_valid_o = 1'b0;
    tx_byte_o  = data_q;
    unique case (state_q)
      ST_ACK: begin
        tx_valid_o = 1'b1;
        tx_byte_o  = `UDS_ACK;
      end
      ST_RD_SEND: tx_valid_o = 1'b1;
      ST_EOT: begin
        tx_valid_o = 1'b1;
        tx_byte_o  = `UDS_EOT;
      end
      default: tx_valid_o = 1'b0;
    endcase
  end

  // Single byte lane per access, data replicated on all lanes
  always_comb begin
    wb_req_o     = '0;
    wb_req_o.cyc = state_q == ST_WR_BUS || state_q == ST_RD_BUS;
    wb_req_o.stb = wb_req_o.cyc;
    wb_req_o.we  = state_q == ST_WR_BUS;
    wb_req_o.adr = addr_q[`UDS_MEM_AW+1:2];
    wb_req_o.sel = wb_sel_t'(1) << lane;
    wb_req_o.dat = {(`UDS_DW/8){data_q}};
  end

endmodule

//--- uart_phy.sv
`timescale 1ns/1ps
`include "uart_dbg_soc_macros.svh"

module uart_phy import uart_dbg_pkg::*; (
  input  logic  clk,
  input  logic  rst_n_i,
  input  logic  uart_rx_i,
  output logic  uart_tx_o,
  output logic  rx_valid_o,
  output byte_t rx_byte_o,
  input  logic  tx_valid_i,
  input  byte_t tx_byte_i,
  output logic  tx_ready_o
);

  localparam int unsigned CNT_W = $clog2(`UDS_CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(`UDS_CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(`UDS_CLKS_PER_BIT / 2 - 1);

  //////////////////////////////////////////////////
  // Receiver
  //////////////////////////////////////////////////

  // Two sync stages plus one for edge detection
  logic [2:0]       rx_sync_q;
  logic             rx_busy_q;
  logic [CNT_W-1:0] rx_cnt_q;
  logic [3:0]       rx_idx_q;
  byte_t            rx_shift_q;
  logic             rx_line;
  logic             rx_start;
  logic             rx_sample;

  assign rx_line   = rx_sync_q[1];
  assign rx_start  = rx_sync_q[2] & ~rx_sync_q[1];
  assign rx_sample = rx_busy_q && rx_cnt_q == '0;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      rx_sync_q  <= '1;
      rx_busy_q  <= 1'b0;
      rx_cnt_q   <= '0;
      rx_idx_q   <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_sync_q  <= {rx_sync_q[1:0], uart_rx_i};
      rx_valid_o <= 1'b0;
      if (!rx_busy_q) begin
        // First sample lands in the middle of the start bit
        if (rx_start) begin
          rx_busy_q <= 1'b1;
          rx_cnt_q  <= HALF_LAST;
          rx_idx_q  <= '0;
        end
      end else if (!rx_sample) begin
        rx_cnt_q <= rx_cnt_q - 1'b1;
      end else begin
        rx_cnt_q <= BIT_LAST;
        rx_idx_q <= rx_idx_q + 1'b1;
        if (rx_idx_q == 4'd0 && rx_line) begin
          // Glitch, not a real start bit
          rx_busy_q <= 1'b0;
        end else if (rx_idx_q == 4'd9) begin
          rx_busy_q  <= 1'b0;
          rx_valid_o <= rx_line;
        end
      end
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk) begin
    if (rx_sample && rx_idx_q >= 4'd1 && rx_idx_q <= 4'd8) begin
      rx_shift_q <= {rx_line, rx_shift_q[7:1]};
    end
  end

  assign rx_byte_o = rx_shift_q;

  //////////////////////////////////////////////////
  // Transmitter
  //////////////////////////////////////////////////

  // Stop, data and start bit, shifted out from bit 0
  logic [9:0]       tx_frame_q;
  logic             tx_busy_q;
  logic [CNT_W-1:0] tx_cnt_q;
  logic [3:0]       tx_idx_q;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      tx_frame_q <= '1;
      tx_busy_q  <= 1'b0;
      tx_cnt_q   <= '0;
      tx_idx_q   <= '0;
    end else if (!tx_busy_q) begin
      if (tx_valid_i) begin
        tx_frame_q <= {1'b1, tx_byte_i, 1'b0};
        tx_busy_q  <= 1'b1;
        tx_cnt_q   <= BIT_LAST;
        tx_idx_q   <= '0;
      end
    end else if (tx_cnt_q != '0) begin
      tx_cnt_q <= tx_cnt_q - 1'b1;
    end else begin
      tx_cnt_q   <= BIT_LAST;
      tx_frame_q <= {1'b1, tx_frame_q[9:1]};
      tx_idx_q   <= tx_idx_q + 1'b1;
      if (tx_idx_q == 4'd9) tx_busy_q <= 1'b0;
    end
  end

  assign uart_tx_o  = tx_frame_q[0];
  assign tx_ready_o = ~tx_busy_q;

endmodule

//--- uart_dbg_pkg.sv
`include "uart_dbg_soc_macros.svh"

package uart_dbg_pkg;

  typedef logic [7:0] byte_t;

  // Byte address, word address plus lane
  typedef logic [`UDS_MEM_AW+1:0] dbg_addr_t;

  // Remaining bytes, upper length bytes are dropped
  typedef logic [15:0] dbg_len_t;

  // Debug engine states
  typedef enum logic [3:0] {
    ST_IDLE,
    ST_ADDR,
    ST_LEN,
    ST_ACK,
    ST_WR_WAIT,
    ST_WR_BUS,
    ST_RD_BUS,
    ST_RD_SEND,
    ST_EOT
  } dbg_state_e;

endpackage

//--- wb_pkg.sv
`include "uart_dbg_soc_macros.svh"

package wb_pkg;

  // Word address into the SRAM
  typedef logic [`UDS_MEM_AW-1:0] wb_adr_t;
  typedef logic [`UDS_DW-1:0]     wb_dat_t;
  // One enable per byte lane
  typedef logic [`UDS_DW/8-1:0]   wb_sel_t;

  // Master to slave
  typedef struct packed {
    logic    cyc;
    logic    stb;
    logic    we;
    wb_adr_t adr;
    wb_sel_t sel;
    wb_dat_t dat;
  } wb_req_t;

  // Slave to master
  typedef struct packed {
    logic    ack;
    wb_dat_t dat;
  } wb_rsp_t;

endpackage

//--- uart_dbg_soc_macros.svh
`ifndef UART_DBG_SOC_MACROS_SVH
`define UART_DBG_SOC_MACROS_SVH

//////////////////////////////////////////////////
// Serial line timing
//////////////////////////////////////////////////

// Clock cycles per UART bit
`define UDS_CLKS_PER_BIT 16

//////////////////////////////////////////////////
// Bus and memory sizes
//////////////////////////////////////////////////

// SRAM word address bits, 256 words
`define UDS_MEM_AW 8
`define UDS_DW 32

//////////////////////////////////////////////////
// Debug protocol bytes
//////////////////////////////////////////////////

`define UDS_CMD_READ  8'h11
`define UDS_CMD_WRITE 8'h12
`define UDS_ACK       8'h06
`define UDS_EOT       8'h04

// Bytes per address or length field
`define UDS_FIELD_BYTES 8

`endif
